//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_frame_decoder -f frame_decoder.f
	./obj_dir/Vtb_frame_decoder

clean:
	rm -rf obj_dir

//--- fd_byte_realigner.sv
`timescale 1ns/10ps

module fd_byte_realigner (
    input  logic                   glb_clk,
    input  logic                   glb_areset_n,
    input  fd_types_pkg::fd_beat_t pay_beat,
    input  logic                   pay_valid,
    output logic                   pay_ready,
    output logic [7:0]             l0,
    output logic                   l0_valid,
    output fd_types_pkg::fd_beat_t al_beat,
    output logic                   al_valid,
    input  logic                   al_ready,
    input  logic                   frame_done
);
    import fd_types_pkg::*;

    logic [23:0] hold_data;
    logic [2:0]  hold_keep;
    logic        flush_pend;
    logic        tail_done;
    logic        out_free;
    logic        pay_fire;

    assign out_free  = !al_valid || al_ready;
    assign pay_ready = out_free && !flush_pend && !tail_done;
    assign pay_fire  = pay_valid && pay_ready;

    always_ff @(posedge glb_clk or negedge glb_areset_n)
    begin
        if (!glb_areset_n)
        begin
            l0_valid   <= 1'b0;
            al_valid   <= 1'b0;
            flush_pend <= 1'b0;
            tail_done  <= 1'b0;
        end
        else if (frame_done)
        begin
            l0_valid   <= 1'b0;
            al_valid   <= 1'b0;
            flush_pend <= 1'b0;
            tail_done  <= 1'b0;
        end
        else if (out_free)
        begin
            if (flush_pend)
            begin
                al_valid   <= 1'b1;
                flush_pend <= 1'b0;
                tail_done  <= 1'b1;
            end
            else if (pay_fire)
            begin
                l0_valid <= 1'b1;
                if (!l0_valid)
                begin
                    // single-beat payload goes out right away
                    al_valid  <= pay_beat.last;
                    tail_done <= pay_beat.last;
                end
                else
                begin
                    al_valid <= 1'b1;
                    if (pay_beat.last)
                    begin
                        tail_done  <= (pay_beat.keep == 4'h1);
                        flush_pend <= (pay_beat.keep != 4'h1);
                    end
                end
            end
            else
                al_valid <= 1'b0;
        end
    end

    always_ff @(posedge glb_clk)
    begin
        if (out_free && flush_pend)
            al_beat <= '{data: {8'h00, hold_data}, keep: {1'b0, hold_keep}, last: 1'b1};
        else if (pay_fire)
        begin
            hold_data <= pay_beat.data[31:8];
            hold_keep <= pay_beat.keep[3:1];
            if (!l0_valid)
            begin
                l0 <= pay_beat.data[7:0];
                // keep of zero marks an empty payload to the egress
                al_beat <= '{data: {8'h00, pay_beat.data[31:8]},
                             keep: {1'b0, pay_beat.keep[3:1]},
                             last: 1'b1};
            end
            else
                al_beat <= '{data: {pay_beat.data[7:0], hold_data},
                             keep: 4'hf,
                             last: pay_beat.last && (pay_beat.keep == 4'h1)};
        end
    end

endmodule

//--- fd_cfg_pkg.sv
package fd_cfg_pkg;

    // output ports behind the decoder
    localparam int unsigned NUM_PORTS = 4;

    // port i answers to LABEL_BASE + i
    localparam logic [7:0] LABEL_BASE = 8'h01;

    // reserved labels, never routed
    localparam logic [7:0] LABEL_END  = 8'hff;
    localparam logic [7:0] LABEL_NONE = 8'hfe;

    // queue fill level above which ECN gets marked
    localparam logic [31:0] CONGEST_THRESHOLD = 32'd3000;
    localparam logic [7:0]  ECN_CONGESTED     = 8'h01;

    // da, da/sa, sa, lt/ecn/label
    localparam int unsigned HDR_WORDS = 4;

endpackage

//--- fd_egress_sequencer.sv
`timescale 1ns/10ps

module fd_egress_sequencer (
    input  logic                     glb_clk,
    input  logic                     glb_areset_n,
    input  fd_types_pkg::fd_header_t route_hdr,
    input  logic                     route_valid,
    input  logic [7:0]               l0,
    input  logic                     l0_valid,
    input  fd_types_pkg::fd_beat_t   al_beat,
    input  logic                     al_valid,
    output logic                     al_ready,
    output fd_types_pkg::fd_beat_t   m_beat,
    output logic                     m_valid,
    input  logic                     m_ready,
    output logic                     frame_done
);
    import fd_cfg_pkg::*;
    import fd_types_pkg::*;

    logic        busy;
    logic [2:0]  hcnt;
    logic        out_free;
    logic        start;
    logic        in_hdr;
    logic        hdr_last;
    logic [31:0] hdr_word;

    assign out_free   = !m_valid || m_ready;
    assign frame_done = m_valid && m_ready && m_beat.last;
    assign start      = !busy && route_valid && l0_valid;
    assign in_hdr     = busy && out_free && (hcnt < 3'(HDR_WORDS));
    // empty payload, so word 3 closes the frame
    assign hdr_last   = (hcnt == 3'(HDR_WORDS - 1)) && al_valid && (al_beat.keep == 4'h0);
    assign al_ready   = busy && out_free && !frame_done
                        && ((hcnt == 3'(HDR_WORDS)) || hdr_last);

    always_comb
    begin
        case (hcnt[1:0])
            2'd0:    hdr_word = route_hdr.da[31:0];
            2'd1:    hdr_word = {route_hdr.sa[15:0], route_hdr.da[47:32]};
            2'd2:    hdr_word = route_hdr.sa[47:16];
            default: hdr_word = {l0, route_hdr.ecn, route_hdr.length_type};
        endcase
    end

    always_ff @(posedge glb_clk or negedge glb_areset_n)
    begin
        if (!glb_areset_n)
        begin
            m_valid <= 1'b0;
            busy    <= 1'b0;
            hcnt    <= 3'd0;
        end
        else if (frame_done)
        begin
            m_valid <= 1'b0;
            busy    <= 1'b0;
            hcnt    <= 3'd0;
        end
        else if (start || in_hdr)
        begin
            m_valid <= 1'b1;
            busy    <= 1'b1;
            hcnt    <= hcnt + 3'd1;
        end
        else if (busy && out_free)
            m_valid <= al_valid;
    end

    always_ff @(posedge glb_clk)
    begin
        if (start || in_hdr)
            m_beat <= '{data: hdr_word, keep: 4'hf, last: hdr_last};
        else if (al_ready && al_valid)
            m_beat <= al_beat;
    end

    a_stall_stable: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

//--- fd_header_parser.sv
`timescale 1ns/10ps

module fd_header_parser (
    input  logic                    glb_clk,
    input  logic                    glb_areset_n,
    input  fd_types_pkg::fd_beat_t  s_beat,
    input  logic                    s_valid,
    output logic                    s_ready,
    output fd_types_pkg::fd_beat_t  pay_beat,
    output logic                    pay_valid,
    input  logic                    pay_ready,
    output fd_types_pkg::fd_header_t hdr,
    output logic                    hdr_valid,
    input  logic                    frame_done
);
    import fd_cfg_pkg::*;
    import fd_types_pkg::*;

    typedef enum logic [1:0] {
        PH_HDR,
        PH_PAY,
        PH_WAIT
    } phase_t;

    phase_t     phase;
    logic [1:0] wcnt;
    logic       s_fire;

    assign s_ready   = (phase == PH_HDR) || ((phase == PH_PAY) && pay_ready);
    assign s_fire    = s_valid && s_ready;
    assign pay_valid = (phase == PH_PAY) && s_valid;
    assign pay_beat  = s_beat;

    always_ff @(posedge glb_clk or negedge glb_areset_n)
    begin
        if (!glb_areset_n)
        begin
            phase     <= PH_HDR;
            wcnt      <= 2'd0;
            hdr_valid <= 1'b0;
        end
        else
        begin
            hdr_valid <= 1'b0;
            case (phase)
                PH_HDR:
                begin
                    if (s_fire)
                    begin
                        wcnt <= wcnt + 2'd1;
                        if (wcnt == 2'(HDR_WORDS - 1))
                        begin
                            phase     <= PH_PAY;
                            hdr_valid <= 1'b1;
                        end
                    end
                end
                PH_PAY:
                begin
                    if (s_fire && s_beat.last) phase <= PH_WAIT;
                end
                PH_WAIT:
                begin
                    // hold off the next frame until egress is through
                    if (frame_done) phase <= PH_HDR;
                end
                default: phase <= PH_HDR;
            endcase
        end
    end

    // header words land straight in their fields
    always_ff @(posedge glb_clk)
    begin
        if (s_fire && (phase == PH_HDR))
        begin
            case (wcnt)
                2'd0: hdr.da[31:0] <= s_beat.data;
                2'd1:
                begin
                    hdr.da[47:32] <= s_beat.data[15:0];
                    hdr.sa[15:0]  <= s_beat.data[31:16];
                end
                2'd2: hdr.sa[47:16] <= s_beat.data;
                default:
                begin
                    hdr.length_type <= s_beat.data[15:0];
                    hdr.ecn         <= s_beat.data[23:16];
                    hdr.label       <= s_beat.data[31:24];
                end
            endcase
        end
    end

    a_keep_contiguous: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        s_valid && s_ready |-> s_beat.keep inside {4'h1, 4'h3, 4'h7, 4'hf});

endmodule

//--- fd_port_router.sv
`timescale 1ns/10ps

module fd_port_router (
    input  logic                       glb_clk,
    input  logic                       glb_areset_n,
    input  fd_types_pkg::queue_level_t queue_level,
    input  fd_types_pkg::fd_header_t   hdr,
    input  logic                       hdr_valid,
    input  logic                       frame_done,
    output fd_types_pkg::fd_header_t   route_hdr,
    output logic                       route_valid,
    output fd_types_pkg::port_sel_t    port_sel
);
    import fd_cfg_pkg::*;
    import fd_types_pkg::*;

    port_sel_t sel_next;
    logic      congested;

    // reserved and unknown labels match no port
    always_comb
    begin
        sel_next  = '0;
        congested = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (hdr.label == LABEL_BASE + 8'(i))
            begin
                sel_next[i] = 1'b1;
                congested   = queue_level[i] > CONGEST_THRESHOLD;
            end
        end
    end

    always_ff @(posedge glb_clk or negedge glb_areset_n)
    begin
        if (!glb_areset_n)
        begin
            route_valid <= 1'b0;
            port_sel    <= '0;
        end
        else if (hdr_valid)
        begin
            route_valid <= 1'b1;
            port_sel    <= sel_next;
        end
        else if (frame_done)
        begin
            route_valid <= 1'b0;
            port_sel    <= '0;
        end
    end

    always_ff @(posedge glb_clk)
    begin
        if (hdr_valid)
        begin
            route_hdr     <= hdr;
            route_hdr.ecn <= congested ? ECN_CONGESTED : hdr.ecn;
        end
    end

    a_sel_onehot: assert property (@(posedge glb_clk) disable iff (!glb_areset_n)
        $onehot0(port_sel) && (route_valid || (port_sel == '0)));

endmodule

//--- fd_types_pkg.sv
package fd_types_pkg;

    // one 32-bit stream word, keep contiguous from byte 0
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  keep;
        logic        last;
    } fd_beat_t;

    // decoded frame header
    typedef struct packed {
        logic [47:0] da;
        logic [47:0] sa;
        logic [15:0] length_type;
        logic [7:0]  ecn;
        logic [7:0]  label;
    } fd_header_t;

    // one-hot output port select
    typedef logic [fd_cfg_pkg::NUM_PORTS-1:0] port_sel_t;

    // fill level per output queue
    typedef logic [fd_cfg_pkg::NUM_PORTS-1:0][31:0] queue_level_t;

endpackage

//--- frame_decoder.f
fd_cfg_pkg.sv
fd_types_pkg.sv
fd_header_parser.sv
fd_port_router.sv
fd_byte_realigner.sv
fd_egress_sequencer.sv
frame_decoder.sv
tb_frame_decoder.sv

//--- frame_decoder.sv
`timescale 1ns/10ps

module frame_decoder (
    input  logic                       glb_clk,
    input  logic                       glb_areset_n,
    input  fd_types_pkg::fd_beat_t     s_beat,
    input  logic                       s_valid,
    output logic                       s_ready,
    output fd_types_pkg::fd_beat_t     m_beat,
    output logic                       m_valid,
    input  logic                       m_ready,
    output fd_types_pkg::port_sel_t    port_sel,
    input  fd_types_pkg::queue_level_t queue_level
);
    import fd_types_pkg::*;

    fd_beat_t   pay_beat;
    logic       pay_valid;
    logic       pay_ready;
    fd_header_t hdr;
    logic       hdr_valid;
    fd_header_t route_hdr;
    logic       route_valid;
    logic [7:0] l0;
    logic       l0_valid;
    fd_beat_t   al_beat;
    logic       al_valid;
    logic       al_ready;
    logic       frame_done;

    fd_header_parser u_parser (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_beat       (s_beat),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .pay_beat     (pay_beat),
        .pay_valid    (pay_valid),
        .pay_ready    (pay_ready),
        .hdr          (hdr),
        .hdr_valid    (hdr_valid),
        .frame_done   (frame_done)
    );

    fd_port_router u_router (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .queue_level  (queue_level),
        .hdr          (hdr),
        .hdr_valid    (hdr_valid),
        .frame_done   (frame_done),
        .route_hdr    (route_hdr),
        .route_valid  (route_valid),
        .port_sel     (port_sel)
    );

    fd_byte_realigner u_realigner (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .pay_beat     (pay_beat),
        .pay_valid    (pay_valid),
        .pay_ready    (pay_ready),
        .l0           (l0),
        .l0_valid     (l0_valid),
        .al_beat      (al_beat),
        .al_valid     (al_valid),
        .al_ready     (al_ready),
        .frame_done   (frame_done)
    );

    fd_egress_sequencer u_egress (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .route_hdr    (route_hdr),
        .route_valid  (route_valid),
        .l0           (l0),
        .l0_valid     (l0_valid),
        .al_beat      (al_beat),
        .al_valid     (al_valid),
        .al_ready     (al_ready),
        .m_beat       (m_beat),
        .m_valid      (m_valid),
        .m_ready      (m_ready),
        .frame_done   (frame_done)
    );

endmodule

//--- tb_frame_decoder.sv
`timescale 1ns/10ps

module tb_frame_decoder;
    import fd_cfg_pkg::*;
    import fd_types_pkg::*;

    // 31 frames of well under 100 cycles each, with plenty of margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MAX_BYTES      = 64;

    logic         glb_clk = 1'b0;
    logic         glb_areset_n;
    fd_beat_t     s_beat;
    logic         s_valid;
    logic         s_ready;
    fd_beat_t     m_beat;
    logic         m_valid;
    logic         m_ready = 1'b1;
    port_sel_t    port_sel;
    queue_level_t queue_level;

    integer       seed;
    int           cycle_cnt = 0;
    logic         bp_on;
    logic         bp_pattern [0:255];
    logic         sel_zero_due = 1'b0;
    fd_beat_t     exp_q [$];
    port_sel_t    sel_q [$];

    frame_decoder u_dut (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_beat       (s_beat),
        .s_valid      (s_valid),
        .s_ready      (s_ready),
        .m_beat       (m_beat),
        .m_valid      (m_valid),
        .m_ready      (m_ready),
        .port_sel     (port_sel),
        .queue_level  (queue_level)
    );

    always #5 glb_clk = ~glb_clk;

    always @(posedge glb_clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            abort_run("timeout, the DUT did not finish its frames in time");
    end

    always @(negedge glb_clk)
    begin
        if (bp_on)
            m_ready = bp_pattern[cycle_cnt[7:0]];
        else
            m_ready = 1'b1;
    end

    // output monitor
    always @(posedge glb_clk)
    begin
        if (glb_areset_n && sel_zero_due)
        begin
            check_sel(port_sel, '0);
            sel_zero_due = 1'b0;
        end
        if (glb_areset_n && m_valid && m_ready)
        begin
            if (exp_q.size() == 0)
                abort_run("the DUT sent an output beat that no frame accounts for");
            else
            begin
                check_sel(port_sel, sel_q[0]);
                check_beat(m_beat, exp_q.pop_front());
                if (m_beat.last)
                begin
                    sel_q.delete(0);
                    sel_zero_due = 1'b1;
                end
            end
        end
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_beat(input fd_beat_t got, input fd_beat_t exp);
        fd_beat_t got_m;
        fd_beat_t exp_m;
        string    msg;
        got_m = got;
        exp_m = exp;
        // bytes outside keep carry no data
        for (int b = 0; b < 4; b++)
        begin
            if (!exp.keep[b])
            begin
                got_m.data[8*b +: 8] = 8'h00;
                exp_m.data[8*b +: 8] = 8'h00;
            end
        end
        if (got_m !== exp_m)
        begin
            msg = $sformatf("ERROR m_beat: got data %h keep %h last %h,",
                            got.data, got.keep, got.last);
            abort_run($sformatf("%s expected data %h keep %h last %h",
                                msg, exp.data, exp.keep, exp.last));
        end
    endtask

    task automatic check_sel(input port_sel_t got, input port_sel_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR port_sel: got %h, expected %h", got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
    endtask

    // up to four bytes from first on, keep contiguous from byte 0
    function automatic fd_beat_t pack_bytes(input logic [7:0] pay [0:MAX_BYTES-1],
                                            input int first, input int nbytes);
        fd_beat_t beat;
        beat = '0;
        for (int b = 0; b < 4; b++)
        begin
            if (first + b < nbytes)
            begin
                beat.data[8*b +: 8] = pay[first + b];
                beat.keep[b]        = 1'b1;
            end
        end
        beat.last = (first + 4 >= nbytes);
        return beat;
    endfunction

    task automatic expect_frame(input logic [47:0] da, input logic [47:0] sa,
                                input logic [7:0] label, input logic [7:0] ecn,
                                input logic [15:0] lt, input logic [7:0] pay [0:MAX_BYTES-1],
                                input int nbytes);
        fd_beat_t   beat;
        port_sel_t  sel;
        logic [7:0] ecn_out;
        int         port;
        sel     = '0;
        ecn_out = ecn;
        if ((label >= LABEL_BASE) && (label < LABEL_BASE + 8'(NUM_PORTS)))
        begin
            port      = int'(label - LABEL_BASE);
            sel[port] = 1'b1;
            if (queue_level[port] > CONGEST_THRESHOLD)
                ecn_out = ECN_CONGESTED;
        end
        beat = '{data: da[31:0], keep: 4'hf, last: 1'b0};
        exp_q.push_back(beat);
        beat.data = {sa[15:0], da[47:32]};
        exp_q.push_back(beat);
        beat.data = sa[47:16];
        exp_q.push_back(beat);
        // L0 takes the place of the label
        beat.data = {pay[0], ecn_out, lt};
        beat.last = (nbytes == 1);
        exp_q.push_back(beat);
        // payload one byte shorter, so a 1-byte tail folds into the beat before
        for (int i = 1; i < nbytes; i += 4)
            exp_q.push_back(pack_bytes(pay, i, nbytes));
        sel_q.push_back(sel);
    endtask

    task automatic drive_word(input fd_beat_t beat);
        s_beat  = beat;
        s_valid = 1'b1;
        @(posedge glb_clk);
        while (!s_ready)
            @(posedge glb_clk);
        @(negedge glb_clk);
        s_valid = 1'b0;
    endtask

    task automatic send_frame(input logic [7:0] label, input logic [7:0] ecn, input int nbytes);
        logic [47:0] da;
        logic [47:0] sa;
        logic [15:0] lt;
        logic [7:0]  pay [0:MAX_BYTES-1];
        logic [31:0] rnd;
        fd_beat_t    beat;
        rnd       = $random(seed);
        da[31:0]  = rnd;
        rnd       = $random(seed);
        da[47:32] = rnd[15:0];
        sa[15:0]  = rnd[31:16];
        rnd       = $random(seed);
        sa[47:16] = rnd;
        lt        = 16'(nbytes);
        for (int i = 0; i < nbytes; i++)
        begin
            rnd    = $random(seed);
            pay[i] = rnd[7:0];
        end
        expect_frame(da, sa, label, ecn, lt, pay, nbytes);
        beat = '{data: da[31:0], keep: 4'hf, last: 1'b0};
        drive_word(beat);
        beat.data = {sa[15:0], da[47:32]};
        drive_word(beat);
        beat.data = sa[47:16];
        drive_word(beat);
        beat.data = {label, ecn, lt};
        drive_word(beat);
        for (int i = 0; i < nbytes; i += 4)
            drive_word(pack_bytes(pay, i, nbytes));
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0)
            @(negedge glb_clk);
        check_flag("m_valid", m_valid, 1'b0);
        check_sel(port_sel, '0);
    endtask

    task automatic test_reset();
        check_flag("m_valid", m_valid, 1'b0);
        check_sel(port_sel, '0);
        check_flag("s_ready", s_ready, 1'b1);
    endtask

    task automatic test_realign();
        queue_level = '0;
        send_frame(8'h02, 8'h00, 9);
        wait_idle();
    endtask

    task automatic test_tails();
        for (int n = 1; n <= 4; n++)
        begin
            // tail in the first payload beat, then behind two full beats
            send_frame(8'h01, 8'h00, n);
            wait_idle();
            send_frame(8'h01, 8'h00, 8 + n);
            wait_idle();
        end
    endtask

    task automatic test_routing();
        logic [7:0] labels [0:6];
        labels = '{8'h01, 8'h02, 8'h03, 8'h04, LABEL_NONE, LABEL_END, 8'h20};
        for (int i = 0; i < 7; i++)
        begin
            send_frame(labels[i], 8'h00, 7);
            wait_idle();
        end
    endtask

    task automatic test_congestion();
        queue_level    = '0;
        queue_level[2] = 32'd3001;
        send_frame(8'h03, 8'h02, 6);
        wait_idle();
        queue_level[2] = CONGEST_THRESHOLD;
        send_frame(8'h03, 8'h02, 6);
        wait_idle();
        // congestion on a port the frame does not use
        queue_level[2] = 32'd0;
        queue_level[0] = 32'd5000;
        send_frame(8'h03, 8'h02, 6);
        wait_idle();
        queue_level = '0;
    endtask

    task automatic test_backpressure();
        logic [31:0] rnd;
        for (int i = 0; i < 256; i++)
        begin
            rnd           = $random(seed);
            bp_pattern[i] = (rnd[1:0] != 2'b00);
        end
        queue_level[1] = 32'd4000;
        bp_on          = 1'b1;
        for (int f = 0; f < 12; f++)
        begin
            rnd = $random(seed);
            send_frame(LABEL_BASE + 8'(rnd[1:0]), rnd[15:8], int'(rnd[7:4]) + 1);
        end
        wait_idle();
        bp_on       = 1'b0;
        queue_level = '0;
    endtask

    initial
    begin
        glb_areset_n = 1'b0;
        s_beat       = '0;
        s_valid      = 1'b0;
        queue_level  = '0;
        seed         = 32'hb79b_2a1a;
        bp_on        = 1'b0;
        repeat (10) @(posedge glb_clk);
        @(negedge glb_clk);
        glb_areset_n = 1'b1;
        test_reset();
        test_realign();
        test_tails();
        test_routing();
        test_congestion();
        test_backpressure();
        $display("TESTS PASSED");
        $finish;
    end

endmodule
